//--- source/bpred_pkg.sv
// Shared types and sizes for the fetch-stage branch predictor
// Every RTL file refers to these by scoped name (bpred_pkg::name)
// Covers the address width, the table geometries and the branch kinds
package bpred_pkg;

    // Physical address
    localparam int ADDR_WIDTH = 40;
    typedef logic [ADDR_WIDTH-1:0] addr_t;   // PCs, targets, return addresses

    // Sequential fetch step and the matching PC offset bits
    localparam int INSTR_BYTES = 4;
    localparam int PC_LSB      = 2;          // Bits 1:0 never index a table

    // Return address stack geometry
    localparam int RAS_INDEX_WIDTH = 4;
    localparam int RAS_ENTRIES     = 2 ** RAS_INDEX_WIDTH;
    typedef logic [RAS_INDEX_WIDTH-1:0] ras_ptr_t;   // Wraps modulo 16

    // Branch history table, indexed by PC bits 7:2
    localparam int BHT_INDEX_WIDTH = 6;
    localparam int BHT_ENTRIES     = 2 ** BHT_INDEX_WIDTH;
    typedef logic [BHT_INDEX_WIDTH-1:0] bht_index_t;

    // Two-bit saturating counter whose upper bit means taken
    typedef logic [1:0] sat_counter_t;
    localparam sat_counter_t SAT_RESET = 2'd1;       // Weakly not taken

    // Branch target buffer indexed by PC bits 6:2 with a tag of bits 39:7
    localparam int BTB_INDEX_WIDTH = 5;
    localparam int BTB_ENTRIES     = 2 ** BTB_INDEX_WIDTH;
    localparam int BTB_TAG_WIDTH   = ADDR_WIDTH - BTB_INDEX_WIDTH - PC_LSB;
    typedef logic [BTB_INDEX_WIDTH-1:0] btb_index_t;
    typedef logic [BTB_TAG_WIDTH-1:0]   btb_tag_t;

    // Control-flow kind as classified by decode
    typedef enum logic [2:0] {
        KIND_COND  = 3'd0,   // Conditional branch
        KIND_JUMP  = 3'd1,   // Plain jump
        KIND_CALL  = 3'd2,   // Call that pushes the return address
        KIND_RET   = 3'd3,   // Return that pops
        KIND_CORET = 3'd4    // Return that also calls with push and pop together
    } branch_kind_t;

endpackage

//--- source/return_address_stack.sv
// Circular return address stack for call/return prediction
// Push stores at the head and advances it, pop steps the head back
// Push with pop in one cycle rewrites the current top at the same depth
// The head pointer wraps, so an overflow overwrites the oldest entry
`timescale 1ns/100ps

module return_address_stack (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             push_i,          // Call seen at execute
    input  logic             pop_i,           // Return seen at execute
    input  bpred_pkg::addr_t push_addr_i,     // Call PC plus one instruction
    output bpred_pkg::addr_t return_addr_o    // Current top of stack
);

    // Stack storage without reset
    bpred_pkg::addr_t  stack_q [bpred_pkg::RAS_ENTRIES];

    bpred_pkg::ras_ptr_t head_ptr_q;   // Next free slot
    bpred_pkg::ras_ptr_t top_ptr;      // Most recent push

    // Entry just below the head wraps from 0 to 15
    assign top_ptr = head_ptr_q - 1'b1;

    // Head pointer is the only reset state
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            head_ptr_q <= '0;
        end else if (push_i && !pop_i) begin
            head_ptr_q <= head_ptr_q + 1'b1;   // Grow
        end else if (pop_i && !push_i) begin
            head_ptr_q <= head_ptr_q - 1'b1;   // Shrink
        end
    end

    // Entry writes
    always_ff @(posedge clk_i) begin
        if (push_i && pop_i) begin
            // Co-routine return puts the new address in place of the old top
            stack_q[top_ptr] <= push_addr_i;
        end else if (push_i) begin
            stack_q[head_ptr_q] <= push_addr_i;
        end
    end

    // Combinational read of the top for the fetch-side prediction
    assign return_addr_o = stack_q[top_ptr];

endmodule

//--- source/branch_history_table.sv
// Table of two-bit saturating counters for conditional branches
// Fetch reads the counter at PC bits 7:2 and gets its upper bit
// Execute trains the counter of a resolved conditional branch
// All counters start weakly not taken
`timescale 1ns/100ps

module branch_history_table (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  bpred_pkg::addr_t pc_fetch_i,       // Lookup address
    output logic             predict_taken_o,  // Counter upper bit
    input  logic             train_i,          // Resolved conditional branch
    input  bpred_pkg::addr_t train_pc_i,       // PC of that branch
    input  logic             train_taken_i     // Its outcome
);

    // Counter array
    bpred_pkg::sat_counter_t counters_q [bpred_pkg::BHT_ENTRIES];

    bpred_pkg::bht_index_t   fetch_idx;
    bpred_pkg::bht_index_t   train_idx;
    bpred_pkg::sat_counter_t train_cnt;        // Counter being trained
    bpred_pkg::sat_counter_t train_cnt_next;   // After the saturating step

    // Word-aligned index slices
    assign fetch_idx = pc_fetch_i[bpred_pkg::PC_LSB +: bpred_pkg::BHT_INDEX_WIDTH];
    assign train_idx = train_pc_i[bpred_pkg::PC_LSB +: bpred_pkg::BHT_INDEX_WIDTH];

    assign train_cnt = counters_q[train_idx];

    // Saturating step
    always_comb begin
        train_cnt_next = train_cnt;
        if (train_taken_i) begin
            if (train_cnt != 2'd3) begin
                train_cnt_next = train_cnt + 2'd1;   // Toward strongly taken
            end
        end else begin
            if (train_cnt != 2'd0) begin
                train_cnt_next = train_cnt - 2'd1;   // Toward strongly not taken
            end
        end
    end

    // Every counter resets to weakly not taken
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < bpred_pkg::BHT_ENTRIES; i++) begin
                counters_q[i] <= bpred_pkg::SAT_RESET;
            end
        end else if (train_i) begin
            counters_q[train_idx] <= train_cnt_next;
        end
    end

    // Values 2 and 3 predict taken
    assign predict_taken_o = counters_q[fetch_idx][1];

endmodule

//--- source/branch_target_buffer.sv
// Direct-mapped branch target buffer
// Each set keeps a valid bit, a tag of PC bits 39:7, a target and a kind
// Fetch does a combinational lookup by PC bits 6:2
// A write replaces the whole set, so aliasing branches evict each other
// Valid bits clear on reset; tag, target and kind hold no reset
`timescale 1ns/100ps

module branch_target_buffer (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  bpred_pkg::addr_t        pc_fetch_i,      // Lookup address
    output logic                    hit_o,           // Valid and tag match
    output bpred_pkg::addr_t        target_o,        // Stored target
    output bpred_pkg::branch_kind_t kind_o,          // Stored branch kind
    input  logic                    write_i,         // Allocate or refresh
    input  bpred_pkg::addr_t        write_pc_i,      // Branch PC
    input  bpred_pkg::addr_t        write_target_i,  // Resolved target
    input  bpred_pkg::branch_kind_t write_kind_i     // Resolved kind
);

    // Per-set state
    logic                    valid_q  [bpred_pkg::BTB_ENTRIES];
    bpred_pkg::btb_tag_t     tag_q    [bpred_pkg::BTB_ENTRIES];
    bpred_pkg::addr_t        target_q [bpred_pkg::BTB_ENTRIES];
    bpred_pkg::branch_kind_t kind_q   [bpred_pkg::BTB_ENTRIES];

    // Lookup side
    bpred_pkg::btb_index_t fetch_idx;
    bpred_pkg::btb_tag_t   fetch_tag;

    // Write side
    bpred_pkg::btb_index_t write_idx;
    bpred_pkg::btb_tag_t   write_tag;

    // Index is bits 6:2, tag is everything above
    assign fetch_idx = pc_fetch_i[bpred_pkg::PC_LSB +: bpred_pkg::BTB_INDEX_WIDTH];
    assign fetch_tag = pc_fetch_i[bpred_pkg::ADDR_WIDTH-1 -: bpred_pkg::BTB_TAG_WIDTH];
    assign write_idx = write_pc_i[bpred_pkg::PC_LSB +: bpred_pkg::BTB_INDEX_WIDTH];
    assign write_tag = write_pc_i[bpred_pkg::ADDR_WIDTH-1 -: bpred_pkg::BTB_TAG_WIDTH];

    // Valid bits are the only reset state here
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < bpred_pkg::BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (write_i) begin
            valid_q[write_idx] <= 1'b1;
        end
    end

    // Set payload is overwritten as a whole
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            tag_q[write_idx]    <= write_tag;
            target_q[write_idx] <= write_target_i;
            kind_q[write_idx]   <= write_kind_i;
        end
    end

    // Combinational lookup
    assign hit_o    = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);
    assign target_o = target_q[fetch_idx];   // Only meaningful on a hit
    assign kind_o   = kind_q[fetch_idx];

endmodule

//--- source/branch_predictor.sv
// Fetch-stage branch predictor built from a target buffer, history table and return stack
// Lookup is combinational from pc_fetch_i, same cycle as fetch
// Execute sends one resolved branch per cycle as a valid-qualified pulse
// Updates land at the next rising edge and a same-cycle lookup sees old state
`timescale 1ns/100ps

module branch_predictor (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  bpred_pkg::addr_t        pc_fetch_i,       // Fetch PC
    output logic                    predict_taken_o,  // Redirect fetch
    output bpred_pkg::addr_t        predict_addr_o,   // Next fetch address
    input  logic                    update_valid_i,   // Qualifies the update
    input  bpred_pkg::addr_t        update_pc_i,      // Resolved branch PC
    input  bpred_pkg::branch_kind_t update_kind_i,    // Resolved kind
    input  logic                    update_taken_i,   // Resolved direction
    input  bpred_pkg::addr_t        update_target_i   // Resolved target
);

    // Update decode
    logic             btb_write;
    logic             bht_train;
    logic             ras_push;
    logic             ras_pop;
    bpred_pkg::addr_t ras_push_addr;   // Return address of the call

    // Lookup results
    logic                    btb_hit;
    bpred_pkg::addr_t        btb_target;
    bpred_pkg::branch_kind_t btb_kind;
    logic                    bht_taken;
    bpred_pkg::addr_t        ras_top;
    bpred_pkg::addr_t        pc_next_seq;   // Fall-through

    // Not-taken conditionals never need a target but everything else does
    assign btb_write = update_valid_i &&
                       (update_taken_i || (update_kind_i != bpred_pkg::KIND_COND));
    assign bht_train = update_valid_i && (update_kind_i == bpred_pkg::KIND_COND);
    assign ras_push  = update_valid_i && ((update_kind_i == bpred_pkg::KIND_CALL) ||
                                          (update_kind_i == bpred_pkg::KIND_CORET));
    assign ras_pop   = update_valid_i && ((update_kind_i == bpred_pkg::KIND_RET) ||
                                          (update_kind_i == bpred_pkg::KIND_CORET));

    assign ras_push_addr = update_pc_i + bpred_pkg::addr_t'(bpred_pkg::INSTR_BYTES);
    assign pc_next_seq   = pc_fetch_i + bpred_pkg::addr_t'(bpred_pkg::INSTR_BYTES);

    branch_target_buffer u_btb (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .pc_fetch_i     (pc_fetch_i),
        .hit_o          (btb_hit),
        .target_o       (btb_target),
        .kind_o         (btb_kind),
        .write_i        (btb_write),
        .write_pc_i     (update_pc_i),
        .write_target_i (update_target_i),
        .write_kind_i   (update_kind_i)
    );

    branch_history_table u_bht (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .pc_fetch_i      (pc_fetch_i),
        .predict_taken_o (bht_taken),
        .train_i         (bht_train),
        .train_pc_i      (update_pc_i),
        .train_taken_i   (update_taken_i)
    );

    return_address_stack u_ras (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .push_i        (ras_push),
        .pop_i         (ras_pop),
        .push_addr_i   (ras_push_addr),
        .return_addr_o (ras_top)
    );

    // Prediction select where a miss falls through to PC plus 4
    always_comb begin
        predict_taken_o = 1'b0;
        predict_addr_o  = pc_next_seq;
        if (btb_hit) begin
            case (btb_kind)
                bpred_pkg::KIND_COND: begin
                    predict_taken_o = bht_taken;   // Direction from the counter
                    if (bht_taken) begin
                        predict_addr_o = btb_target;
                    end
                end
                bpred_pkg::KIND_JUMP, bpred_pkg::KIND_CALL: begin
                    predict_taken_o = 1'b1;
                    predict_addr_o  = btb_target;
                end
                bpred_pkg::KIND_RET, bpred_pkg::KIND_CORET: begin
                    predict_taken_o = 1'b1;
                    predict_addr_o  = ras_top;     // Stack top, not the stored target
                end
                default: begin
                    predict_taken_o = 1'b0;        // Unused encodings fall through
                end
            endcase
        end
    end

endmodule

//--- testbench/branch_predictor_sva.sv
// Concurrent checks on the branch predictor top level
// Attached to every branch_predictor instance by the bind at the bottom
`timescale 1ns/100ps

module branch_predictor_sva (
    input logic             clk_i,
    input logic             rstn_i,
    input bpred_pkg::addr_t pc_fetch_i,
    input logic             predict_taken_i,   // DUT prediction
    input bpred_pkg::addr_t predict_addr_i,
    input logic             btb_hit_i,         // Buffer hit inside the DUT
    input logic             ras_push_i,
    input logic             ras_pop_i,
    input bpred_pkg::addr_t update_pc_i,
    input bpred_pkg::addr_t ras_top_i          // Stack top seen by fetch
);

    // Valid bits just cleared so nothing can hit
    taken_low_after_reset: assert property (
        @(posedge clk_i) $rose(rstn_i) |-> !predict_taken_i
    ) else $error("prediction taken in the first cycle after reset");

    miss_is_sequential: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !btb_hit_i |-> predict_addr_i == pc_fetch_i + bpred_pkg::addr_t'(bpred_pkg::INSTR_BYTES)
    ) else $error("miss did not predict the fetch PC plus one instruction");

    // Push alone makes the return address of that call the new top
    push_sets_top: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (ras_push_i && !ras_pop_i) |=>
            ras_top_i == $past(update_pc_i) + bpred_pkg::addr_t'(bpred_pkg::INSTR_BYTES)
    ) else $error("stack top after a call is not the call PC plus one instruction");

    outputs_known: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !$isunknown({predict_taken_i, predict_addr_i})
    ) else $error("prediction output is unknown");

endmodule

bind branch_predictor branch_predictor_sva u_sva (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .pc_fetch_i      (pc_fetch_i),
    .predict_taken_i (predict_taken_o),
    .predict_addr_i  (predict_addr_o),
    .btb_hit_i       (btb_hit),
    .ras_push_i      (ras_push),
    .ras_pop_i       (ras_pop),
    .update_pc_i     (update_pc_i),
    .ras_top_i       (ras_top)
);

//--- testbench/tb_branch_predictor.sv
// Testbench for the branch predictor top level
// Vectors with expected results come from testbench/bpred_input.txt
// Inputs change on the falling edge and lookups are checked just before the rising edge
`timescale 1ns/100ps

module tb_branch_predictor;

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 5;
    localparam string VECTOR_FILE  = "testbench/bpred_input.txt";

    logic                    clk_i;
    logic                    rstn_i;
    bpred_pkg::addr_t        pc_fetch_i;
    logic                    predict_taken_o;
    bpred_pkg::addr_t        predict_addr_o;
    logic                    update_valid_i;
    bpred_pkg::addr_t        update_pc_i;
    bpred_pkg::branch_kind_t update_kind_i;
    logic                    update_taken_i;
    bpred_pkg::addr_t        update_target_i;

    string lines [$];      // Vector file minus comments
    int    vector_lines;   // Lines that cost a clock cycle
    int    cycle_count;
    int    cycle_limit;    // Zero until the file is loaded
    int    test_errors;
    int    total_errors;
    int    tests_passed;
    int    tests_failed;
    bit    test_open;
    int    test_num;
    string test_name;

    branch_predictor uut (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .pc_fetch_i      (pc_fetch_i),
        .predict_taken_o (predict_taken_o),
        .predict_addr_o  (predict_addr_o),
        .update_valid_i  (update_valid_i),
        .update_pc_i     (update_pc_i),
        .update_kind_i   (update_kind_i),
        .update_taken_i  (update_taken_i),
        .update_target_i (update_target_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Watchdog
    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic record_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic check_taken(input logic got, input logic expected,
                               input bpred_pkg::addr_t pc);
        if (got !== expected) begin
            $display("error at %0t: taken for pc %h is %b, expected %b",
                     $time, pc, got, expected);
            record_error();
        end
    endtask

    task automatic check_addr(input bpred_pkg::addr_t got, input bpred_pkg::addr_t expected,
                              input bpred_pkg::addr_t pc);
        if (got !== expected) begin
            $display("error at %0t: next address for pc %h is %h, expected %h",
                     $time, pc, got, expected);
            record_error();
        end
    endtask

    task automatic drive_update(input bpred_pkg::addr_t pc, input int kind, input int taken,
                                input bpred_pkg::addr_t target);
        logic [2:0] kind_bits;
        kind_bits       = kind[2:0];
        update_valid_i  = 1'b1;
        update_pc_i     = pc;
        update_kind_i   = bpred_pkg::branch_kind_t'(kind_bits);
        update_taken_i  = taken[0];
        update_target_i = target;
    endtask

    task automatic clear_update();
        update_valid_i  = 1'b0;
        update_pc_i     = '0;
        update_kind_i   = bpred_pkg::KIND_COND;
        update_taken_i  = 1'b0;
        update_target_i = '0;
    endtask

    // Sample just ahead of the rising edge when outputs have settled
    task automatic check_lookup(input bpred_pkg::addr_t pc, input int exp_taken,
                                input bpred_pkg::addr_t exp_addr);
        #(CLK_PERIOD / 2 - 1);
        check_taken(predict_taken_o, exp_taken[0], pc);
        check_addr(predict_addr_o, exp_addr, pc);
    endtask

    task automatic close_test();
        if (test_open) begin
            if (test_errors == 0) begin
                tests_passed++;
                $display("test %0d %s: passed", test_num, test_name);
            end else begin
                tests_failed++;
                $display("test %0d %s: failed with %0d errors", test_num, test_name,
                         test_errors);
            end
        end
        test_open = 1'b0;
    endtask

    task automatic load_vectors();
        int    fd;
        string line;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VECTOR_FILE);
            total_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
                if (line.getc(0) != "T") begin
                    vector_lines++;   // Markers take no cycle
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_line(input string line);
        byte              op;
        string            rest;
        string            name;
        int               fields;
        int               num;
        int               kind;
        int               taken;
        int               exp_taken;
        bpred_pkg::addr_t pc;
        bpred_pkg::addr_t target;
        bpred_pkg::addr_t look_pc;
        bpred_pkg::addr_t exp_addr;
        op     = line.getc(0);
        rest   = line.substr(1, line.len() - 1);
        fields = 0;
        case (op)
            "T": begin
                fields = $sscanf(rest, "%d %s", num, name);
                close_test();
                test_num    = num;
                test_name   = name;
                test_errors = 0;
                test_open   = 1'b1;
            end
            "U": begin
                fields = $sscanf(rest, "%h %d %d %h", pc, kind, taken, target);
                @(negedge clk_i);
                drive_update(pc, kind, taken, target);
                pc_fetch_i = '0;   // Parked on a PC that never hits
            end
            "L": begin
                fields = $sscanf(rest, "%h %d %h", look_pc, exp_taken, exp_addr);
                @(negedge clk_i);
                clear_update();
                pc_fetch_i = look_pc;
                check_lookup(look_pc, exp_taken, exp_addr);
            end
            "B": begin
                fields = $sscanf(rest, "%h %d %d %h %h %d %h", pc, kind, taken, target,
                                 look_pc, exp_taken, exp_addr);
                @(negedge clk_i);
                drive_update(pc, kind, taken, target);
                pc_fetch_i = look_pc;   // Same cycle as the update so old state is expected
                check_lookup(look_pc, exp_taken, exp_addr);
            end
            default: begin
                fields = -1;
            end
        endcase
        if ((op == "T" && fields != 2) || (op == "U" && fields != 4) ||
            (op == "L" && fields != 3) || (op == "B" && fields != 7) || fields < 0) begin
            $display("vector line could not be read: %s", line);
            record_error();
        end
    endtask

    initial begin
        clk_i        = 1'b0;
        rstn_i       = 1'b0;
        pc_fetch_i   = '0;
        clear_update();
        cycle_count  = 0;
        cycle_limit  = 0;
        vector_lines = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_open    = 1'b0;
        test_num     = 0;
        test_name    = "";

        load_vectors();
        if (lines.size() == 0) begin
            $display("no vectors were read from %s", VECTOR_FILE);
            total_errors++;
        end
        cycle_limit = 2 * vector_lines + 50;

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        @(negedge clk_i);
        clear_update();
        pc_fetch_i = '0;
        close_test();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/bpred_input.txt
# T num name | U pc kind taken target | L pc exp_taken exp_addr   (addresses in hex)
# B pc kind taken target lookup_pc exp_taken exp_addr  update and lookup in one cycle
# kind 0 cond, 1 jump, 2 call, 3 ret, 4 call-return
T 1 after_reset
L 0000001000 0 0000001004
L 00000020a4 0 00000020a8
L 8000000ffc 0 8000001000
L ffffffffff 0 0000000003
T 2 cond_training
U 0000001040 0 0 0000000f00
L 0000001040 0 0000001044
U 0000001040 0 1 0000000f00
L 0000001040 0 0000001044
U 0000001040 0 1 0000000f00
L 0000001040 1 0000000f00
U 0000001040 0 0 0000000f00
U 0000001040 0 0 0000000f00
L 0000001040 0 0000001044
U 0000001080 0 1 0000002000
U 0000001080 0 1 0000002000
U 0000001080 0 1 0000002000
L 0000001080 1 0000002000
U 0000001080 0 0 0000002000
L 0000001080 1 0000002000
U 0000001080 0 0 0000002000
L 0000001080 0 0000001084
T 3 jump_call_alias
B 0000003010 1 1 0000004400 0000003010 0 0000003014
L 0000003010 1 0000004400
U 0000003020 2 1 0000005000
L 0000003020 1 0000005000
U 0000007010 1 1 0000006000
L 0000007010 1 0000006000
L 0000003010 0 0000003014
T 4 call_return
U 000000810c 3 1 0000003024
U 0000009000 2 1 000000a000
U 000000a040 2 1 000000b000
U 000000b008 2 1 000000c000
L 0000009000 1 000000a000
L 000000810c 1 000000b00c
U 000000810c 3 1 000000b00c
L 000000810c 1 000000a044
U 000000810c 3 1 000000a044
L 000000810c 1 0000009004
U 000000810c 3 1 0000009004
T 5 coret_and_overflow
U 000000d000 2 1 000000f000
U 000000d100 2 1 000000f000
L 000000810c 1 000000d104
U 000000e014 4 1 000000d104
L 000000810c 1 000000e018
L 000000e014 1 000000e018
U 000000810c 3 1 000000e018
L 000000810c 1 000000d004
U 000000810c 3 1 000000d004
U 0000010000 2 1 0000020000
U 0000010100 2 1 0000020000
U 0000010200 2 1 0000020000
U 0000010300 2 1 0000020000
U 0000010400 2 1 0000020000
U 0000010500 2 1 0000020000
U 0000010600 2 1 0000020000
U 0000010700 2 1 0000020000
U 0000010800 2 1 0000020000
U 0000010900 2 1 0000020000
U 0000010a00 2 1 0000020000
U 0000010b00 2 1 0000020000
U 0000010c00 2 1 0000020000
U 0000010d00 2 1 0000020000
U 0000010e00 2 1 0000020000
U 0000010f00 2 1 0000020000
U 0000011000 2 1 0000020000
L 000000810c 1 0000011004
U 000000810c 3 1 0000011004
L 000000810c 1 0000010f04
U 000000810c 3 1 0000010f04
U 000000810c 3 1 0000010e04
U 000000810c 3 1 0000010d04
U 000000810c 3 1 0000010c04
U 000000810c 3 1 0000010b04
U 000000810c 3 1 0000010a04
U 000000810c 3 1 0000010904
U 000000810c 3 1 0000010804
U 000000810c 3 1 0000010704
U 000000810c 3 1 0000010604
U 000000810c 3 1 0000010504
U 000000810c 3 1 0000010404
U 000000810c 3 1 0000010304
U 000000810c 3 1 0000010204
U 000000810c 3 1 0000010104
L 000000810c 1 0000011004

//--- sim.f
source/bpred_pkg.sv
source/return_address_stack.sv
source/branch_history_table.sv
source/branch_target_buffer.sv
source/branch_predictor.sv
testbench/branch_predictor_sva.sv
testbench/tb_branch_predictor.sv

//--- Makefile
# Verilator build and run of the branch predictor testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_branch_predictor
FILELIST  := sim.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
VECTORS   := testbench/bpred_input.txt
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(VECTORS)
	./$(BIN) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
